// ==== sources.f ====
procPkg.sv
pipeBus.sv
fetch.sv
decode.sv
hazardUnit.sv
execute.sv
memory.sv
proc.sv
procTb.sv

// ==== procTb.sv ====
//######################################
// random forward-only programs from seed 90
// DUT is reset before every program
//######################################
`timescale 1ns/10ps
`default_nettype none

module procTb;

  logic clk;
  logic rstN;
  logic run;
  logic imemWe;
  logic [5:0] imemAddr;
  logic [15:0] imemData;
  logic commitValid;
  logic [2:0] commitReg;
  logic [15:0] commitData;
  logic halted;
  logic err;

  logic [31:0] rngState;
  logic [15:0] prog [64];
  logic [2:0] expReg [256];
  logic [15:0] expData [256];
  logic [15:0] modelRegs [8];
  logic [15:0] shadowRegs [8];
  logic modelIllegal;
  logic checking;
  logic timedOut;
  int expCount;
  int expIdx;
  int mismatchErr;
  int otherErr;
  int progLen;

  proc i_proc (
    .clk(clk), .rstN(rstN), .run(run), .imemWe(imemWe), .imemAddr(imemAddr),
    .imemData(imemData), .commitValid(commitValid), .commitReg(commitReg),
    .commitData(commitData), .halted(halted), .err(err)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int rnd(input int span);
    rngState = xorshift(rngState);
    return int'(rngState % span);
  endfunction

  // last word is always halt and transfers only go forward
  task automatic buildProgram(input int n);
    int i;
    int kind;
    int off;
    int room;
    logic [3:0] op;
    logic [2:0] rd;
    logic [2:0] rs;
    logic [2:0] rt;
    logic [2:0] lastRd;
    logic [5:0] imm;
    lastRd = 3'd0;
    prog[n - 1] = 16'hA000;
    i = 0;
    while (i < n - 1) begin
      kind = rnd(16);
      rd = 3'(rnd(8));
      // reuse the last destination often to build dependences
      rs = (rnd(2) == 0) ? lastRd : 3'(rnd(8));
      rt = (rnd(3) == 0) ? lastRd : 3'(rnd(8));
      imm = 6'(rnd(64));
      room = n - 2 - i;
      if (kind < 5) begin
        op = 4'(rnd(4));
        prog[i] = {op, rd, rs, rt, 3'b000};
        lastRd = rd;
      end else if (kind < 9) begin
        // addi or load
        op = (kind < 7) ? 4'h4 : 4'h5;
        prog[i] = {op, rd, rs, imm};
        lastRd = rd;
      end else if (kind < 11) begin
        prog[i] = {4'h6, rd, rs, imm};
      end else if (kind < 13) begin
        op = (kind == 11) ? 4'h7 : 4'h8;
        off = rnd(room + 1);
        prog[i] = {op, rd, rs, 6'(off)};
      end else if (kind < 15 && room >= 2) begin
        // jump over a halt or an illegal word
        off = 1 + rnd(room);
        prog[i] = {4'h9, 12'(off)};
        op = (rnd(2) == 0) ? 4'hA : 4'hB + 4'(rnd(5));
        prog[i + 1] = {op, 12'h000};
        i = i + 1;
      end else if (kind == 15 && rnd(8) == 0) begin
        prog[i] = 16'hF000;
      end else begin
        prog[i] = {4'h4, rd, rs, imm};
        lastRd = rd;
      end
      i = i + 1;
    end
  endtask

  // instruction-set model that fills the expected write list
  function automatic int refModel(input int n);
    logic [15:0] mem [16];
    logic [15:0] ins;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] sx6;
    logic [15:0] sx12;
    logic [15:0] val;
    logic [3:0] op;
    logic [2:0] rd;
    logic wr;
    logic done;
    int pc;
    int cnt;
    int steps;
    for (int k = 0; k < 16; k++) begin
      mem[k] = 16'h0000;
    end
    for (int k = 0; k < 8; k++) begin
      modelRegs[k] = 16'h0000;
    end
    modelIllegal = 1'b0;
    pc = 0;
    cnt = 0;
    done = 1'b0;
    for (steps = 0; steps < 256 && !done && pc < 64; steps++) begin
      ins = prog[pc];
      op = ins[15:12];
      rd = ins[11:9];
      a = modelRegs[ins[8:6]];
      b = modelRegs[ins[5:3]];
      sx6 = {{10{ins[5]}}, ins[5:0]};
      sx12 = {{4{ins[11]}}, ins[11:0]};
      wr = 1'b0;
      val = 16'h0000;
      pc = pc + 1;
      case (op)
        4'h0: begin
          wr = 1'b1;
          val = a + b;
        end
        4'h1: begin
          wr = 1'b1;
          val = a - b;
        end
        4'h2: begin
          wr = 1'b1;
          val = a & b;
        end
        4'h3: begin
          wr = 1'b1;
          val = a ^ b;
        end
        4'h4: begin
          wr = 1'b1;
          val = a + sx6;
        end
        4'h5: begin
          wr = 1'b1;
          val = mem[4'(a + sx6)];
        end
        4'h6: mem[4'(a + sx6)] = modelRegs[rd];
        4'h7: if (a == 16'h0000) pc = pc + int'($signed(sx6));
        4'h8: if (a != 16'h0000) pc = pc + int'($signed(sx6));
        4'h9: pc = pc + int'($signed(sx12));
        4'hA: done = 1'b1;
        default: begin
          modelIllegal = 1'b1;
          done = 1'b1;
        end
      endcase
      if (wr) begin
        modelRegs[rd] = val;
        expReg[cnt] = rd;
        expData[cnt] = val;
        cnt = cnt + 1;
      end
    end
    return cnt;
  endfunction

  task automatic loadProgram(input int n);
    for (int a = 0; a < n; a++) begin
      @(posedge clk);
      imemWe <= 1'b1;
      imemAddr <= 6'(a);
      imemData <= prog[a];
    end
    @(posedge clk);
    imemWe <= 1'b0;
  endtask

  task automatic waitHalted(output logic late);
    late = 1'b1;
    for (int c = 0; c < 2000; c++) begin
      @(negedge clk);
      if (halted) begin
        late = 1'b0;
        break;
      end
    end
    assert (!late) else begin
      $display("timeout: halted did not rise within 2000 cycles");
      otherErr++;
    end
  endtask

  task automatic checkEnd(input int p);
    assert (expIdx == expCount) else begin
      $display("program %0d committed %0d writes, model expects %0d", p, expIdx, expCount);
      otherErr++;
    end
    assert (err == modelIllegal) else begin
      $display("Mismatch err: got %h expected %h", err, modelIllegal);
      mismatchErr++;
    end
    for (int r = 0; r < 8; r++) begin
      assert (shadowRegs[r] == modelRegs[r]) else begin
        $display("Mismatch r%0d: got %h expected %h", r, shadowRegs[r], modelRegs[r]);
        mismatchErr++;
      end
    end
  endtask

  // commit checker sampled away from the clock edge
  always @(negedge clk) begin
    if (checking && commitValid) begin
      assert (!halted) else begin
        $display("commit to r%0d after halted rose", commitReg);
        otherErr++;
      end
      assert (expIdx < expCount) else begin
        $display("commit to r%0d after the expected writes ran out", commitReg);
        otherErr++;
      end
      if (expIdx < expCount) begin
        assert (commitReg == expReg[expIdx]) else begin
          $display("Mismatch commitReg: got %h expected %h", commitReg, expReg[expIdx]);
          mismatchErr++;
        end
        assert (commitData == expData[expIdx]) else begin
          $display("Mismatch commitData: got %h expected %h", commitData, expData[expIdx]);
          mismatchErr++;
        end
      end
      shadowRegs[commitReg] = commitData;
      expIdx++;
    end
  end

  initial begin
    rstN = 1'b0;
    run = 1'b0;
    imemWe = 1'b0;
    imemAddr = '0;
    imemData = '0;
    rngState = 32'd90;
    checking = 1'b0;
    timedOut = 1'b0;
    expCount = 0;
    expIdx = 0;
    mismatchErr = 0;
    otherErr = 0;
    for (int p = 0; p < 20 && !timedOut; p++) begin
      progLen = 16 + rnd(16);
      buildProgram(progLen);
      expCount = refModel(progLen);
      @(posedge clk);
      rstN <= 1'b0;
      run <= 1'b0;
      repeat (2) @(posedge clk);
      rstN <= 1'b1;
      expIdx = 0;
      for (int r = 0; r < 8; r++) begin
        shadowRegs[r] = 16'h0000;
      end
      checking = 1'b1;
      loadProgram(progLen);
      @(posedge clk);
      run <= 1'b1;
      waitHalted(timedOut);
      if (!timedOut) begin
        // window for any late commit
        repeat (8) @(negedge clk);
        checkEnd(p);
      end
      checking = 1'b0;
    end
    $display("errors: %0d mismatches, %0d other failures", mismatchErr, otherErr);
    if (mismatchErr == 0 && otherErr == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== proc.sv ====
//######################################
// load imem with run low, then raise run
// halted also rises for a retired illegal
//######################################
`timescale 1ns/10ps
`default_nettype none

module proc #(
  parameter int imemAddrW = 6,
  parameter int dmemAddrW = 4
) (
  input wire clk,
  input wire rstN,
  input wire run,
  input wire imemWe,
  input wire [imemAddrW-1:0] imemAddr,
  input wire [procPkg::dataW-1:0] imemData,
  output logic commitValid,
  output logic [procPkg::regAddrW-1:0] commitReg,
  output logic [procPkg::dataW-1:0] commitData,
  output logic halted,
  output logic err
);

  logic ifValid;
  logic [procPkg::dataW-1:0] ifInstr;
  logic [procPkg::dataW-1:0] ifPc1;
  logic stall;
  logic flush;
  logic haltSeen;
  logic [procPkg::dataW-1:0] redirectPc;
  procPkg::fwdSelT fwdA;
  procPkg::fwdSelT fwdB;

  decExBus decExIf ();
  exMemBus exMemIf ();
  memWbBus memWbIf ();

  fetch #(.imemAddrW(imemAddrW)) fetch0 (
    .clk(clk), .rstN(rstN), .run(run), .imemWe(imemWe), .imemAddr(imemAddr),
    .imemData(imemData), .stall(stall), .flush(flush), .redirectPc(redirectPc),
    .haltSeen(haltSeen), .ifValid(ifValid), .ifInstr(ifInstr), .ifPc1(ifPc1)
  );

  decode decode0 (
    .clk(clk), .rstN(rstN), .ifValid(ifValid), .ifInstr(ifInstr), .ifPc1(ifPc1),
    .stall(stall), .flush(flush), .haltSeen(haltSeen), .decEx(decExIf), .memWb(memWbIf)
  );

  hazardUnit hazard0 (
    .ifValid(ifValid), .ifInstr(ifInstr), .decEx(decExIf), .exMem(exMemIf),
    .memWb(memWbIf), .stall(stall), .fwdA(fwdA), .fwdB(fwdB)
  );

  execute execute0 (
    .clk(clk), .rstN(rstN), .flush(flush), .fwdA(fwdA), .fwdB(fwdB),
    .decEx(decExIf), .memWb(memWbIf), .exMem(exMemIf)
  );

  memory #(.dmemAddrW(dmemAddrW)) memory0 (
    .clk(clk), .rstN(rstN), .exMem(exMemIf), .memWb(memWbIf),
    .flush(flush), .redirectPc(redirectPc)
  );

  // commit mirrors the register file write
  assign commitValid = memWbIf.valid && memWbIf.regWrite;
  assign commitReg = memWbIf.rd;
  assign commitData = memWbIf.result;

  // an illegal op also freezes fetch, so it ends the run as well
  always_ff @(posedge clk) begin
    if (!rstN) begin
      halted <= 1'b0;
    end else if (memWbIf.valid && (memWbIf.halt || memWbIf.illegal)) begin
      halted <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      err <= 1'b0;
    end else if (memWbIf.valid && memWbIf.illegal) begin
      err <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== memory.sv ====
//######################################
// data addresses wrap at dmemAddrW bits
//######################################
`timescale 1ns/10ps
`default_nettype none

module memory #(
  parameter int dmemAddrW = 4
) (
  input wire clk,
  input wire rstN,
  exMemBus.consumer exMem,
  memWbBus.producer memWb,
  output logic flush,
  output logic [procPkg::dataW-1:0] redirectPc
);

  logic [procPkg::dataW-1:0] dmem [2**dmemAddrW];
  logic [dmemAddrW-1:0] addr;
  logic [procPkg::dataW-1:0] loadData;

  assign addr = exMem.aluResult[dmemAddrW-1:0];
  assign loadData = dmem[addr];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 2**dmemAddrW; i++) begin
        dmem[i] <= '0;
      end
    end else if (exMem.valid && exMem.memWrite) begin
      dmem[addr] <= exMem.storeData;
    end
  end

  // taken transfer kills the three younger slots
  assign flush = exMem.valid && exMem.taken;
  assign redirectPc = exMem.target;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      memWb.valid <= 1'b0;
    end else begin
      memWb.valid <= exMem.valid;
    end
  end

  always_ff @(posedge clk) begin
    memWb.rd <= exMem.rd;
    memWb.regWrite <= exMem.regWrite;
    memWb.result <= (exMem.wbSel == procPkg::wbMem) ? loadData : exMem.aluResult;
    memWb.halt <= exMem.halt;
    memWb.illegal <= exMem.illegal;
  end

endmodule

`default_nettype wire

// ==== execute.sv ====
//######################################
// branch targets are PC+1 plus the
// sign-extended immediate from decode
//######################################
`timescale 1ns/10ps
`default_nettype none

module execute (
  input wire clk,
  input wire rstN,
  input wire flush,
  input wire procPkg::fwdSelT fwdA,
  input wire procPkg::fwdSelT fwdB,
  decExBus.consumer decEx,
  memWbBus.consumer memWb,
  exMemBus.producer exMem
);

  logic [procPkg::dataW-1:0] aVal;
  logic [procPkg::dataW-1:0] regB;
  logic [procPkg::dataW-1:0] storeVal;
  logic [procPkg::dataW-1:0] aluB;
  logic [procPkg::dataW-1:0] aluOut;
  logic taken;

  function automatic logic [procPkg::dataW-1:0] pick(
    input procPkg::fwdSelT sel,
    input logic [procPkg::dataW-1:0] own,
    input logic [procPkg::dataW-1:0] exVal,
    input logic [procPkg::dataW-1:0] wbVal
  );
    case (sel)
      procPkg::fwdExMem: return exVal;
      procPkg::fwdMemWb: return wbVal;
      default: return own;
    endcase
  endfunction

  assign aVal = pick(fwdA, decEx.opa, exMem.aluResult, memWb.result);
  assign regB = pick(fwdB, decEx.opb, exMem.aluResult, memWb.result);
  assign storeVal = pick(fwdB, decEx.storeData, exMem.aluResult, memWb.result);
  assign aluB = decEx.useImm ? decEx.imm : regB;

  always_comb begin
    case (decEx.aluOp)
      procPkg::aluSub: aluOut = aVal - aluB;
      procPkg::aluAnd: aluOut = aVal & aluB;
      procPkg::aluXor: aluOut = aVal ^ aluB;
      default: aluOut = aVal + aluB;
    endcase
  end

  // zero test on rs
  assign taken = decEx.isJump || (decEx.isBranchZ && aVal == '0) ||
                 (decEx.isBranchNz && aVal != '0);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      exMem.valid <= 1'b0;
    end else begin
      exMem.valid <= decEx.valid && !flush;
    end
  end

  always_ff @(posedge clk) begin
    exMem.aluResult <= aluOut;
    exMem.storeData <= storeVal;
    exMem.target <= decEx.pc1 + decEx.imm;
    exMem.taken <= taken;
    exMem.rd <= decEx.rd;
    exMem.regWrite <= decEx.regWrite;
    exMem.memRead <= decEx.memRead;
    exMem.memWrite <= decEx.memWrite;
    exMem.wbSel <= decEx.wbSel;
    exMem.halt <= decEx.halt;
    exMem.illegal <= decEx.illegal;
  end

endmodule

`default_nettype wire

// ==== hazardUnit.sv ====
//######################################
// EX/MEM forwarding skips loads because
// the load-use stall covers that case
//######################################
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
  input wire ifValid,
  input wire [procPkg::dataW-1:0] ifInstr,
  decExBus.consumer decEx,
  exMemBus.consumer exMem,
  memWbBus.consumer memWb,
  output logic stall,
  output procPkg::fwdSelT fwdA,
  output procPkg::fwdSelT fwdB
);

  procPkg::opcodeT op;
  logic [procPkg::regAddrW-1:0] srcA;
  logic [procPkg::regAddrW-1:0] srcB;
  logic readsA;
  logic readsB;
  logic exOk;
  logic wbOk;

  function automatic procPkg::fwdSelT source(
    input logic [procPkg::regAddrW-1:0] idx,
    input logic exHit,
    input logic [procPkg::regAddrW-1:0] exRd,
    input logic wbHit,
    input logic [procPkg::regAddrW-1:0] wbRd
  );
    // youngest producer wins
    if (exHit && exRd == idx) begin
      return procPkg::fwdExMem;
    end
    if (wbHit && wbRd == idx) begin
      return procPkg::fwdMemWb;
    end
    return procPkg::fwdNone;
  endfunction

  assign op = procPkg::opcodeT'(ifInstr[procPkg::opHi:procPkg::opLo]);
  assign srcA = ifInstr[procPkg::rsHi:procPkg::rsLo];

  // source registers of the IF/ID instruction
  always_comb begin
    readsA = 1'b0;
    readsB = 1'b0;
    srcB = ifInstr[procPkg::rtHi:procPkg::rtLo];
    case (op)
      procPkg::opAdd, procPkg::opSub, procPkg::opAnd, procPkg::opXor: begin
        readsA = 1'b1;
        readsB = 1'b1;
      end
      procPkg::opAddi, procPkg::opLd, procPkg::opBeqz, procPkg::opBnez: readsA = 1'b1;
      procPkg::opSt: begin
        readsA = 1'b1;
        readsB = 1'b1;
        srcB = ifInstr[procPkg::rdHi:procPkg::rdLo];
      end
      default: ;
    endcase
  end

  assign stall = ifValid && decEx.valid && decEx.memRead && decEx.regWrite &&
                 ((readsA && srcA == decEx.rd) || (readsB && srcB == decEx.rd));

  assign exOk = exMem.valid && exMem.regWrite && !exMem.memRead;
  assign wbOk = memWb.valid && memWb.regWrite;
  assign fwdA = source(decEx.rs, exOk, exMem.rd, wbOk, memWb.rd);
  assign fwdB = source(decEx.rt, exOk, exMem.rd, wbOk, memWb.rd);

endmodule

`default_nettype wire

// ==== decode.sv ====
//######################################
// register file bypasses a same-cycle
// writeback; halt or illegal freezes fetch
//######################################
`timescale 1ns/10ps
`default_nettype none

module decode (
  input wire clk,
  input wire rstN,
  input wire ifValid,
  input wire [procPkg::dataW-1:0] ifInstr,
  input wire [procPkg::dataW-1:0] ifPc1,
  input wire stall,
  input wire flush,
  output logic haltSeen,
  decExBus.producer decEx,
  memWbBus.consumer memWb
);

  procPkg::opcodeT opcode;
  procPkg::aluOpT aluOp;
  procPkg::wbSelT wbSel;
  logic [procPkg::regAddrW-1:0] rsIdx;
  logic [procPkg::regAddrW-1:0] rtIdx;
  logic [procPkg::regAddrW-1:0] rdIdx;
  logic [procPkg::regAddrW-1:0] rbIdx;
  logic [procPkg::dataW-1:0] regs [2**procPkg::regAddrW];
  logic [procPkg::dataW-1:0] rfA;
  logic [procPkg::dataW-1:0] rfB;
  logic [procPkg::dataW-1:0] imm6;
  logic [procPkg::dataW-1:0] imm12;
  logic useImm;
  logic regWrite;
  logic memRead;
  logic memWrite;
  logic isBz;
  logic isBnz;
  logic isJmp;
  logic isHalt;
  logic illegal;
  logic rfWe;
  logic curStop;
  logic haltHeld;

  assign opcode = procPkg::opcodeT'(ifInstr[procPkg::opHi:procPkg::opLo]);
  assign rdIdx = ifInstr[procPkg::rdHi:procPkg::rdLo];
  assign rsIdx = ifInstr[procPkg::rsHi:procPkg::rsLo];
  assign rtIdx = ifInstr[procPkg::rtHi:procPkg::rtLo];
  assign imm6 = {{(procPkg::dataW-procPkg::imm6Hi-1){ifInstr[procPkg::imm6Hi]}},
                 ifInstr[procPkg::imm6Hi:0]};
  assign imm12 = {{(procPkg::dataW-procPkg::imm12Hi-1){ifInstr[procPkg::imm12Hi]}},
                  ifInstr[procPkg::imm12Hi:0]};

  always_comb begin
    aluOp = procPkg::aluAdd;
    wbSel = procPkg::wbAlu;
    useImm = 1'b0;
    regWrite = 1'b0;
    memRead = 1'b0;
    memWrite = 1'b0;
    isBz = 1'b0;
    isBnz = 1'b0;
    isJmp = 1'b0;
    isHalt = 1'b0;
    illegal = 1'b0;
    case (opcode)
      procPkg::opAdd: regWrite = 1'b1;
      procPkg::opSub: begin
        regWrite = 1'b1;
        aluOp = procPkg::aluSub;
      end
      procPkg::opAnd: begin
        regWrite = 1'b1;
        aluOp = procPkg::aluAnd;
      end
      procPkg::opXor: begin
        regWrite = 1'b1;
        aluOp = procPkg::aluXor;
      end
      procPkg::opAddi: begin
        regWrite = 1'b1;
        useImm = 1'b1;
      end
      procPkg::opLd: begin
        regWrite = 1'b1;
        useImm = 1'b1;
        memRead = 1'b1;
        wbSel = procPkg::wbMem;
      end
      procPkg::opSt: begin
        useImm = 1'b1;
        memWrite = 1'b1;
      end
      procPkg::opBeqz: isBz = 1'b1;
      procPkg::opBnez: isBnz = 1'b1;
      procPkg::opJmp: isJmp = 1'b1;
      procPkg::opHalt: isHalt = 1'b1;
      default: illegal = 1'b1;
    endcase
  end

  // store data comes from rd on the second port
  assign rbIdx = memWrite ? rdIdx : rtIdx;
  assign rfWe = memWb.valid && memWb.regWrite;
  assign rfA = (rfWe && memWb.rd == rsIdx) ? memWb.result : regs[rsIdx];
  assign rfB = (rfWe && memWb.rd == rbIdx) ? memWb.result : regs[rbIdx];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 2**procPkg::regAddrW; i++) begin
        regs[i] <= '0;
      end
    end else if (rfWe) begin
      regs[memWb.rd] <= memWb.result;
    end
  end

  // freeze is held until a redirect cancels it
  assign curStop = ifValid && (isHalt || illegal);
  assign haltSeen = haltHeld || curStop;

  always_ff @(posedge clk) begin
    if (!rstN || flush) begin
      haltHeld <= 1'b0;
    end else if (curStop) begin
      haltHeld <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      decEx.valid <= 1'b0;
    end else begin
      decEx.valid <= ifValid && !stall && !flush;
    end
  end

  always_ff @(posedge clk) begin
    decEx.pc1 <= ifPc1;
    decEx.opa <= rfA;
    decEx.opb <= rfB;
    decEx.storeData <= rfB;
    decEx.imm <= isJmp ? imm12 : imm6;
    decEx.rs <= rsIdx;
    decEx.rt <= rbIdx;
    decEx.rd <= rdIdx;
    decEx.aluOp <= aluOp;
    decEx.wbSel <= wbSel;
    decEx.useImm <= useImm;
    decEx.regWrite <= regWrite;
    decEx.memRead <= memRead;
    decEx.memWrite <= memWrite;
    decEx.isBranchZ <= isBz;
    decEx.isBranchNz <= isBnz;
    decEx.isJump <= isJmp;
    decEx.halt <= isHalt;
    decEx.illegal <= illegal;
  end

endmodule

`default_nettype wire

// ==== fetch.sv ====
//######################################
// imem is written through the load port
// only while run is low
//######################################
`timescale 1ns/10ps
`default_nettype none

module fetch #(
  parameter int imemAddrW = 6
) (
  input wire clk,
  input wire rstN,
  input wire run,
  input wire imemWe,
  input wire [imemAddrW-1:0] imemAddr,
  input wire [procPkg::dataW-1:0] imemData,
  input wire stall,
  input wire flush,
  input wire [procPkg::dataW-1:0] redirectPc,
  input wire haltSeen,
  output logic ifValid,
  output logic [procPkg::dataW-1:0] ifInstr,
  output logic [procPkg::dataW-1:0] ifPc1
);

  logic [procPkg::dataW-1:0] imem [2**imemAddrW];
  logic [imemAddrW-1:0] pc;
  logic [imemAddrW-1:0] pcNext;
  logic issue;

  assign pcNext = pc + 1'b1;
  // bubbles while stopped or frozen by a halt
  assign issue = run && !haltSeen;

  always_ff @(posedge clk) begin
    if (imemWe) begin
      imem[imemAddr] <= imemData;
    end
  end

  // flush beats stall, stall beats issue
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= '0;
      ifValid <= 1'b0;
    end else if (flush) begin
      pc <= redirectPc[imemAddrW-1:0];
      ifValid <= 1'b0;
    end else if (!stall) begin
      ifValid <= issue;
      if (issue) begin
        pc <= pcNext;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!flush && !stall && issue) begin
      ifInstr <= imem[pc];
      ifPc1 <= {{(procPkg::dataW-imemAddrW){1'b0}}, pcNext};
    end
  end

endmodule

`default_nettype wire

// ==== pipeBus.sv ====
//######################################
// in each stage register bus the valid
// bit qualifies every other field
//######################################
`timescale 1ns/10ps
`default_nettype none

interface decExBus;
  logic valid;
  logic [procPkg::dataW-1:0] pc1;
  logic [procPkg::dataW-1:0] opa;
  logic [procPkg::dataW-1:0] opb;
  logic [procPkg::dataW-1:0] storeData;
  logic [procPkg::dataW-1:0] imm;
  logic [procPkg::regAddrW-1:0] rs;
  logic [procPkg::regAddrW-1:0] rt;
  logic [procPkg::regAddrW-1:0] rd;
  procPkg::aluOpT aluOp;
  procPkg::wbSelT wbSel;
  logic useImm;
  logic regWrite;
  logic memRead;
  logic memWrite;
  logic isBranchZ;
  logic isBranchNz;
  logic isJump;
  logic halt;
  logic illegal;

  modport producer (output valid, pc1, opa, opb, storeData, imm, rs, rt, rd, aluOp, wbSel,
                    useImm, regWrite, memRead, memWrite, isBranchZ, isBranchNz, isJump,
                    halt, illegal);
  modport consumer (input valid, pc1, opa, opb, storeData, imm, rs, rt, rd, aluOp, wbSel,
                    useImm, regWrite, memRead, memWrite, isBranchZ, isBranchNz, isJump,
                    halt, illegal);
endinterface

interface exMemBus;
  logic valid;
  logic [procPkg::dataW-1:0] aluResult;
  logic [procPkg::dataW-1:0] storeData;
  logic [procPkg::dataW-1:0] target;
  logic taken;
  logic [procPkg::regAddrW-1:0] rd;
  logic regWrite;
  logic memRead;
  logic memWrite;
  procPkg::wbSelT wbSel;
  logic halt;
  logic illegal;

  modport producer (output valid, aluResult, storeData, target, taken, rd, regWrite,
                    memRead, memWrite, wbSel, halt, illegal);
  modport consumer (input valid, aluResult, storeData, target, taken, rd, regWrite,
                    memRead, memWrite, wbSel, halt, illegal);
endinterface

interface memWbBus;
  logic valid;
  logic [procPkg::regAddrW-1:0] rd;
  logic regWrite;
  logic [procPkg::dataW-1:0] result;
  logic halt;
  logic illegal;

  modport producer (output valid, rd, regWrite, result, halt, illegal);
  modport consumer (input valid, rd, regWrite, result, halt, illegal);
endinterface

`default_nettype wire

// ==== procPkg.sv ====
//######################################
// word sizes, opcodes and field slices
// opcode codes above opHalt are illegal
//######################################
`default_nettype none

package procPkg;

  localparam int dataW = 16;
  localparam int regAddrW = 3;
  localparam int opcodeW = 4;

  // instruction field positions
  localparam int opHi = 15;
  localparam int opLo = 12;
  localparam int rdHi = 11;
  localparam int rdLo = 9;
  localparam int rsHi = 8;
  localparam int rsLo = 6;
  localparam int rtHi = 5;
  localparam int rtLo = 3;
  localparam int imm6Hi = 5;
  localparam int imm12Hi = 11;

  typedef enum logic [opcodeW-1:0] {
    opAdd  = 4'h0,
    opSub  = 4'h1,
    opAnd  = 4'h2,
    opXor  = 4'h3,
    opAddi = 4'h4,
    opLd   = 4'h5,
    opSt   = 4'h6,
    opBeqz = 4'h7,
    opBnez = 4'h8,
    opJmp  = 4'h9,
    opHalt = 4'hA
  } opcodeT;

  typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluXor} aluOpT;

  typedef enum logic {wbAlu, wbMem} wbSelT;

  // operand source picked by the hazard unit for execute
  typedef enum logic [1:0] {fwdNone, fwdExMem, fwdMemWb} fwdSelT;

endpackage

`default_nettype wire
